/* list.f */
+incdir+.
wg_pkg.sv
wg_resp_sampler.sv
wg_write_tracker.sv
wg_regs.sv
write_guard_top.sv
wg_tb.sv

/* Bender.yml */
package:
  name: write_guard

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - wg_pkg.sv
      - wg_resp_sampler.sv
      - wg_write_tracker.sv
      - wg_regs.sv
      - write_guard_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - wg_tb.sv

/* wg_tb.sv */
// Write guard testbench
// Random AW/B traffic against a slot model, error capture and reset request checks

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_tb
  import wg_pkg::*;
;

  localparam int SLOTS        = `WG_SLOTS;
  localparam int CNT_MAX      = (1 << `WG_CNT_W) - 1;
  localparam int PHASES       = 5;
  // Largest load in the random phase is 200 * (1 + 3 * 3 + 3)
  localparam int LONGEST_LOAD = 2600;
  localparam int CYCLE_LIMIT  = PHASES * LONGEST_LOAD * `WG_PRESCALE + 2000;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  logic                  aw_valid_i;
  logic                  aw_ready_i;
  logic [`WG_ID_W-1:0]   aw_id_i;
  logic [`WG_ADDR_W-1:0] aw_addr_i;
  logic [`WG_LEN_W-1:0]  aw_len_i;
  logic                  b_valid_i;
  logic                  b_ready_i;
  logic [`WG_ID_W-1:0]   b_id_i;
  logic                  reg_req_i;
  logic                  reg_we_i;
  reg_op_e               reg_addr_i;
  logic [31:0]           reg_wdata_i;
  logic [31:0]           reg_rdata_o;
  logic                  irq_o;
  logic                  reset_req_o;
  logic                  reset_clear_i;

  // Reference model of the slot table
  logic                  m_valid [SLOTS];
  logic [`WG_ID_W-1:0]   m_id [SLOTS];
  logic [`WG_ADDR_W-1:0] m_addr [SLOTS];
  int                    m_len [SLOTS];
  int                    m_cnt [SLOTS];
  int                    m_seq [SLOTS];
  int                    m_seq_next = 0;
  int                    m_presc;
  int                    m_budget;
  logic                  m_bfire;
  logic [`WG_ID_W-1:0]   m_bid;
  logic                  m_hold;
  logic                  m_irq;
  int                    m_last_lat = 0;
  int                    m_n_retire = 0;
  int                    m_n_err = 0;
  logic [`WG_ID_W-1:0]   m_err_id = '0;

  logic [`WG_ID_W-1:0]   open_ids [$];
  int                    errors = 0;
  int                    cycles = 0;
  int                    b_sent = 0;

  write_guard_top UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_i    (aw_ready_i),
    .aw_id_i       (aw_id_i),
    .aw_addr_i     (aw_addr_i),
    .aw_len_i      (aw_len_i),
    .b_valid_i     (b_valid_i),
    .b_ready_i     (b_ready_i),
    .b_id_i        (b_id_i),
    .reg_req_i     (reg_req_i),
    .reg_we_i      (reg_we_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_rdata_o   (reg_rdata_o),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .reset_clear_i (reset_clear_i)
  );

  always #50 clk_i = ~clk_i;

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Expected REG_STATUS layout
  function automatic logic [31:0] status_word(input logic to, input logic unw,
                                              input logic [`WG_ID_W-1:0] id);
    status_word = (32'(id) << 4) | (32'(unw) << 1) | 32'(to);
  endfunction

  // Model follows the DUT inputs sampled at each rising edge
  always @(posedge clk_i) begin : model
    int   sum_len;
    int   free_i;
    int   exp_i;
    int   ret_i;
    int   load;
    logic tick_now;
    logic unw;
    logic err;
    logic acc;
    if (!rst_ni) begin
      for (int i = 0; i < SLOTS; i++) begin
        m_valid[i] = 1'b0;
      end
      m_presc  = 0;
      m_budget = 0;
      m_bfire  = 1'b0;
      m_hold   = 1'b0;
      m_irq    = 1'b0;
    end else begin
      check_eq(irq_o, m_irq, "irq_o against model");
      check_eq(reset_req_o, m_hold, "reset_req_o against model");
      tick_now = (m_presc == `WG_PRESCALE - 1);
      sum_len  = 0;
      free_i   = -1;
      exp_i    = -1;
      ret_i    = -1;
      for (int i = SLOTS - 1; i >= 0; i--) begin
        if (!m_valid[i]) begin
          free_i = i;
        end else begin
          sum_len += m_len[i];
          if (m_cnt[i] == 0) begin
            exp_i = i;
          end
          // Oldest write of the answered ID
          if ((m_id[i] == m_bid) && ((ret_i < 0) || (m_seq[i] < m_seq[ret_i]))) begin
            ret_i = i;
          end
        end
      end
      unw  = m_bfire && (ret_i < 0);
      err  = (exp_i >= 0) || unw;
      acc  = aw_valid_i && aw_ready_i && (free_i >= 0) && !m_hold && !err;
      load = m_budget * (1 + sum_len + int'(aw_len_i));
      if (load > CNT_MAX) begin
        load = CNT_MAX;
      end
      if (m_bfire && (ret_i >= 0) && !err) begin
        m_last_lat     = m_cnt[ret_i];
        m_valid[ret_i] = 1'b0;
        m_n_retire++;
      end
      for (int i = 0; i < SLOTS; i++) begin
        if (m_valid[i] && tick_now && (m_cnt[i] != 0)) begin
          m_cnt[i]--;
        end
      end
      if (acc) begin
        m_valid[free_i] = 1'b1;
        m_id[free_i]    = aw_id_i;
        m_addr[free_i]  = aw_addr_i;
        m_len[free_i]   = aw_len_i;
        m_cnt[free_i]   = load;
        m_seq[free_i]   = m_seq_next;
        m_seq_next++;
      end
      if (err) begin
        m_err_id = (exp_i >= 0) ? m_id[exp_i] : m_bid;
        for (int i = 0; i < SLOTS; i++) begin
          m_valid[i] = 1'b0;
        end
        m_hold = 1'b1;
        m_n_err++;
      end else if (reset_clear_i || (reg_req_i && reg_we_i && (reg_addr_i == REG_RESET) &&
                                     reg_wdata_i[0])) begin
        m_hold = 1'b0;
      end
      m_irq = err;
      if (reg_req_i && reg_we_i && (reg_addr_i == REG_BUDGET)) begin
        m_budget = int'(reg_wdata_i[`WG_CNT_W-1:0]);
      end
      m_bfire = b_valid_i && b_ready_i;
      if (m_bfire) begin
        m_bid = b_id_i;
      end
      m_presc = (m_presc + 1) % `WG_PRESCALE;
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
    end
  end

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic send_aw(input logic [`WG_ID_W-1:0] id, input logic [`WG_ADDR_W-1:0] addr,
                         input logic [`WG_LEN_W-1:0] len);
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_id_i    <= id;
    aw_addr_i  <= addr;
    aw_len_i   <= len;
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
  endtask

  task automatic send_b(input logic [`WG_ID_W-1:0] id);
    @(posedge clk_i);
    b_valid_i <= 1'b1;
    b_id_i    <= id;
    @(posedge clk_i);
    b_valid_i <= 1'b0;
  endtask

  task automatic reg_write(input reg_op_e op, input logic [31:0] data);
    @(posedge clk_i);
    reg_req_i   <= 1'b1;
    reg_we_i    <= 1'b1;
    reg_addr_i  <= op;
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    reg_we_i  <= 1'b0;
  endtask

  task automatic reg_read(input reg_op_e op, output logic [31:0] data);
    @(posedge clk_i);
    reg_req_i  <= 1'b1;
    reg_we_i   <= 1'b0;
    reg_addr_i <= op;
    @(posedge clk_i);
    reg_req_i <= 1'b0;
    @(negedge clk_i);
    data = reg_rdata_o;
  endtask

  task automatic pulse_clear();
    @(posedge clk_i);
    reset_clear_i <= 1'b1;
    @(posedge clk_i);
    reset_clear_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic wait_irq(input int max_cycles);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (irq_o !== 1'b1) begin
      if (waited >= max_cycles) begin
        $display("Timeout: no interrupt within %0d cycles at %0t ns", max_cycles, $time);
        $display("Checks failed");
        $fatal(1, "interrupt wait expired");
      end else begin
        waited++;
        @(negedge clk_i);
      end
    end
  endtask

  // Answer one open write and compare the retire latency with the model
  task automatic answer_open(input int pick);
    logic [`WG_ID_W-1:0] id;
    logic [31:0]         rd;
    id = open_ids[pick];
    open_ids.delete(pick);
    send_b(id);
    idle(2);
    reg_read(REG_LATENCY, rd);
    check_eq(rd, m_last_lat, "REG_LATENCY after retire");
    b_sent++;
  endtask

  initial begin : stim
    logic [31:0]           rd;
    logic [`WG_ADDR_W-1:0] addr_a;
    logic [`WG_ADDR_W-1:0] addr_b;
    logic [`WG_ID_W-1:0]   id;
    int                    coin;
    void'($urandom(32'h5f47dd3b));
    rst_ni        = 1'b0;
    aw_valid_i    = 1'b0;
    aw_ready_i    = 1'b1;
    aw_id_i       = '0;
    aw_addr_i     = '0;
    aw_len_i      = '0;
    b_valid_i     = 1'b0;
    b_ready_i     = 1'b1;
    b_id_i        = '0;
    reg_req_i     = 1'b0;
    reg_we_i      = 1'b0;
    reg_addr_i    = REG_BUDGET;
    reg_wdata_i   = '0;
    reset_clear_i = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Register access and reset values
    @(negedge clk_i);
    check_eq(irq_o, 1'b0, "irq_o after reset");
    check_eq(reset_req_o, 1'b0, "reset_req_o after reset");
    reg_read(REG_STATUS, rd);
    check_eq(rd, 32'd0, "REG_STATUS after reset");
    reg_read(REG_RESET, rd);
    check_eq(rd, 32'd0, "REG_RESET after reset");
    reg_read(REG_BUDGET, rd);
    check_eq(rd, 32'd0, "REG_BUDGET after reset");
    reg_write(REG_BUDGET, 32'd200);
    reg_read(REG_BUDGET, rd);
    check_eq(rd, 32'd200, "REG_BUDGET read back");

    // Random traffic answered well inside the budget
    for (int k = 0; k < 30; k++) begin
      coin = $urandom_range(1, 0);
      if ((open_ids.size() == 0) || ((open_ids.size() < SLOTS) && (coin == 1))) begin
        id = $urandom_range(7, 0);
        send_aw(id, $urandom(), $urandom_range(3, 0));
        open_ids.push_back(id);
        idle(2);
      end else begin
        answer_open($urandom_range(open_ids.size() - 1, 0));
      end
    end
    while (open_ids.size() > 0) begin
      answer_open(0);
    end
    check_eq(m_n_retire, b_sent, "retire count");
    check_eq(m_n_err, 0, "errors during random traffic");

    // Unanswered write, load is 4 * (1 + 0 + 1) ticks
    reg_write(REG_BUDGET, 32'd4);
    addr_a = $urandom();
    send_aw(3'd5, addr_a, 8'd1);
    wait_irq(10 * `WG_PRESCALE + 8);
    check_eq(m_err_id, 3'd5, "model timeout ID");
    reg_read(REG_STATUS, rd);
    check_eq(rd, status_word(1'b1, 1'b0, m_err_id), "REG_STATUS on timeout");
    reg_read(REG_IRQ_ADDR, rd);
    check_eq(rd, addr_a, "REG_IRQ_ADDR on timeout");
    idle(6);
    @(negedge clk_i);
    check_eq(reset_req_o, 1'b1, "reset_req_o held");
    pulse_clear();
    check_eq(reset_req_o, 1'b0, "reset_req_o after reset_clear_i");

    // Same ID twice, only the first answered
    addr_a = $urandom();
    addr_b = $urandom();
    send_aw(3'd2, addr_a, 8'd2);
    send_aw(3'd2, addr_b, 8'd0);
    idle(1);
    send_b(3'd2);
    wait_irq(14 * `WG_PRESCALE + 16);
    reg_read(REG_STATUS, rd);
    check_eq(rd, status_word(1'b1, 1'b0, 3'd2), "REG_STATUS on second timeout");
    reg_read(REG_IRQ_ADDR, rd);
    check_eq(rd, addr_b, "REG_IRQ_ADDR holds second write");
    reg_write(REG_RESET, 32'd1);
    @(negedge clk_i);
    check_eq(reset_req_o, 1'b0, "reset_req_o after REG_RESET write");

    // Response with no outstanding write
    send_b(3'd6);
    wait_irq(16);
    reg_read(REG_STATUS, rd);
    check_eq(rd, status_word(1'b0, 1'b1, 3'd6), "REG_STATUS on unwanted");
    pulse_clear();

    // Error clears the slots, writes during the reset request are dropped
    reg_write(REG_BUDGET, 32'd200);
    send_aw(3'd3, $urandom(), 8'd0);
    send_aw(3'd3, $urandom(), 8'd1);
    idle(2);
    send_b(3'd6);
    wait_irq(16);
    send_aw(3'd1, $urandom(), 8'd0);
    idle(2);
    reg_write(REG_RESET, 32'd1);
    send_b(3'd3);
    wait_irq(16);
    reg_read(REG_STATUS, rd);
    check_eq(rd, status_word(1'b0, 1'b1, 3'd3), "REG_STATUS for forgotten write");
    reg_write(REG_RESET, 32'd1);
    send_b(3'd1);
    wait_irq(16);
    reg_read(REG_STATUS, rd);
    check_eq(rd, status_word(1'b0, 1'b1, 3'd1), "REG_STATUS for dropped write");

    // Valid without ready is no handshake on either channel
    reg_write(REG_RESET, 32'd1);
    aw_ready_i <= 1'b0;
    send_aw(3'd4, $urandom(), 8'd0);
    aw_ready_i <= 1'b1;
    b_ready_i  <= 1'b0;
    send_b(3'd4);
    b_ready_i  <= 1'b1;
    idle(4);
    send_b(3'd4);
    wait_irq(16);
    reg_read(REG_STATUS, rd);
    check_eq(rd, status_word(1'b0, 1'b1, 3'd4), "REG_STATUS for write without ready");
    pulse_clear();
    idle(4);
    check_eq(m_n_err, 7, "error count");

    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* write_guard_top.sv */
// Write guard top level
// Watches AW and B handshakes and flags late or unexpected write responses

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module write_guard_top
  import wg_pkg::*;
(
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  wire                  aw_valid_i,
  input  wire                  aw_ready_i,
  input  wire [`WG_ID_W-1:0]   aw_id_i,
  input  wire [`WG_ADDR_W-1:0] aw_addr_i,
  input  wire [`WG_LEN_W-1:0]  aw_len_i,
  input  wire                  b_valid_i,
  input  wire                  b_ready_i,
  input  wire [`WG_ID_W-1:0]   b_id_i,
  input  wire                  reg_req_i,
  input  wire                  reg_we_i,
  input  wire reg_op_e         reg_addr_i,
  input  wire [31:0]           reg_wdata_i,
  output logic [31:0]          reg_rdata_o,
  output logic                 irq_o,
  output logic                 reset_req_o,
  input  wire                  reset_clear_i
);

  logic                  tick;
  logic                  b_fire;
  logic [`WG_ID_W-1:0]   b_id;
  logic [`WG_CNT_W-1:0]  budget;
  logic                  err_valid;
  logic                  err_timeout;
  logic                  err_unwanted;
  logic [`WG_ID_W-1:0]   err_id;
  logic [`WG_ADDR_W-1:0] err_addr;
  logic                  retire_valid;
  logic [`WG_CNT_W-1:0]  retire_latency;

  wg_resp_sampler u_sampler (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .b_valid_i (b_valid_i),
    .b_ready_i (b_ready_i),
    .b_id_i    (b_id_i),
    .tick_o    (tick),
    .b_fire_o  (b_fire),
    .b_id_o    (b_id)
  );

  wg_write_tracker u_tracker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .aw_valid_i       (aw_valid_i),
    .aw_ready_i       (aw_ready_i),
    .aw_id_i          (aw_id_i),
    .aw_addr_i        (aw_addr_i),
    .aw_len_i         (aw_len_i),
    .tick_i           (tick),
    .b_fire_i         (b_fire),
    .b_id_i           (b_id),
    .budget_i         (budget),
    .hold_i           (reset_req_o),
    .err_valid_o      (err_valid),
    .err_timeout_o    (err_timeout),
    .err_unwanted_o   (err_unwanted),
    .err_id_o         (err_id),
    .err_addr_o       (err_addr),
    .retire_valid_o   (retire_valid),
    .retire_latency_o (retire_latency)
  );

  wg_regs u_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .reg_req_i        (reg_req_i),
    .reg_we_i         (reg_we_i),
    .reg_addr_i       (reg_addr_i),
    .reg_wdata_i      (reg_wdata_i),
    .err_valid_i      (err_valid),
    .err_timeout_i    (err_timeout),
    .err_unwanted_i   (err_unwanted),
    .err_id_i         (err_id),
    .err_addr_i       (err_addr),
    .retire_valid_i   (retire_valid),
    .retire_latency_i (retire_latency),
    .reset_clear_i    (reset_clear_i),
    .budget_o         (budget),
    .irq_o            (irq_o),
    .reset_req_o      (reset_req_o),
    .reg_rdata_o      (reg_rdata_o)
  );

endmodule

`default_nettype wire

/* wg_regs.sv */
// Write guard register block
// Budget setting, error capture, retire latency and the latched reset request

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_regs
  import wg_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire                   reg_req_i,
  input  wire                   reg_we_i,
  input  wire reg_op_e          reg_addr_i,
  input  wire [31:0]            reg_wdata_i,
  input  wire                   err_valid_i,
  input  wire                   err_timeout_i,
  input  wire                   err_unwanted_i,
  input  wire [`WG_ID_W-1:0]    err_id_i,
  input  wire [`WG_ADDR_W-1:0]  err_addr_i,
  input  wire                   retire_valid_i,
  input  wire [`WG_CNT_W-1:0]   retire_latency_i,
  input  wire                   reset_clear_i,
  output logic [`WG_CNT_W-1:0]  budget_o,
  output logic                  irq_o,
  output logic                  reset_req_o,
  output logic [31:0]           reg_rdata_o
);

  logic                  wr_en;
  logic                  rd_en;
  logic                  st_timeout_q;
  logic                  st_unwanted_q;
  logic [`WG_ID_W-1:0]   st_id_q;
  logic [`WG_ADDR_W-1:0] irq_addr_q;
  logic [`WG_CNT_W-1:0]  latency_q;
  logic [31:0]           rd_data;

  assign wr_en = reg_req_i && reg_we_i;
  assign rd_en = reg_req_i && !reg_we_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      budget_o      <= '0;
      st_timeout_q  <= 1'b0;
      st_unwanted_q <= 1'b0;
      st_id_q       <= '0;
      irq_addr_q    <= '0;
      latency_q     <= '0;
    end else begin
      if (wr_en && (reg_addr_i == REG_BUDGET)) begin
        budget_o <= reg_wdata_i[`WG_CNT_W-1:0];
      end
      // A new error overrides a status clear in the same cycle
      if (err_valid_i) begin
        st_timeout_q  <= err_timeout_i;
        st_unwanted_q <= err_unwanted_i;
        st_id_q       <= err_id_i;
        irq_addr_q    <= err_addr_i;
      end else if (wr_en && (reg_addr_i == REG_STATUS)) begin
        st_timeout_q  <= 1'b0;
        st_unwanted_q <= 1'b0;
        st_id_q       <= '0;
      end
      if (retire_valid_i) begin
        latency_q <= retire_latency_i;
      end
    end
  end

  // Interrupt pulse and sticky reset request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_o       <= 1'b0;
      reset_req_o <= 1'b0;
    end else begin
      irq_o <= err_valid_i;
      if (err_valid_i) begin
        reset_req_o <= 1'b1;
      end else if (reset_clear_i ||
                   (wr_en && (reg_addr_i == REG_RESET) && reg_wdata_i[0])) begin
        reset_req_o <= 1'b0;
      end
    end
  end

  // Read mux
  always_comb begin
    rd_data = '0;
    case (reg_addr_i)
      REG_BUDGET: rd_data[`WG_CNT_W-1:0] = budget_o;
      REG_STATUS: begin
        rd_data[0]              = st_timeout_q;
        rd_data[1]              = st_unwanted_q;
        rd_data[4 +: `WG_ID_W]  = st_id_q;
      end
      REG_IRQ_ADDR: rd_data[`WG_ADDR_W-1:0] = irq_addr_q;
      REG_LATENCY:  rd_data[`WG_CNT_W-1:0]  = latency_q;
      REG_RESET:    rd_data[0]              = reset_req_o;
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rdata_o <= '0;
    end else if (rd_en) begin
      reg_rdata_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

/* wg_write_tracker.sv */
// Write guard transaction tracker
// Keeps outstanding writes in per-ID linked lists, counts down their budgets
// and reports timeouts and responses that match no outstanding write

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_write_tracker
  import wg_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire                   aw_valid_i,
  input  wire                   aw_ready_i,
  input  wire [`WG_ID_W-1:0]    aw_id_i,
  input  wire [`WG_ADDR_W-1:0]  aw_addr_i,
  input  wire [`WG_LEN_W-1:0]   aw_len_i,
  input  wire                   tick_i,
  input  wire                   b_fire_i,
  input  wire [`WG_ID_W-1:0]    b_id_i,
  input  wire [`WG_CNT_W-1:0]   budget_i,
  input  wire                   hold_i,
  output logic                  err_valid_o,
  output logic                  err_timeout_o,
  output logic                  err_unwanted_o,
  output logic [`WG_ID_W-1:0]   err_id_o,
  output logic [`WG_ADDR_W-1:0] err_addr_o,
  output logic                  retire_valid_o,
  output logic [`WG_CNT_W-1:0]  retire_latency_o
);

  localparam int SLOTS  = `WG_SLOTS;
  localparam int IDX_W  = (SLOTS > 1) ? $clog2(SLOTS) : 1;
  localparam int NIDS   = 1 << `WG_ID_W;
  localparam int SUM_W  = `WG_LEN_W + $clog2(SLOTS + 2);
  localparam int PROD_W = `WG_CNT_W + SUM_W;

  typedef logic [IDX_W-1:0] idx_t;

  // Slot table
  slot_state_e            state_q [SLOTS];
  slot_state_e            state_d [SLOTS];
  slot_state_e            slot_view [SLOTS];
  logic [`WG_ID_W-1:0]    id_q [SLOTS];
  logic [`WG_ADDR_W-1:0]  addr_q [SLOTS];
  logic [`WG_LEN_W-1:0]   len_q [SLOTS];
  logic [`WG_CNT_W-1:0]   cnt_q [SLOTS];
  idx_t                   next_q [SLOTS];

  // Oldest and youngest slot of each ID
  idx_t head_q [NIDS];
  idx_t head_d [NIDS];
  idx_t tail_q [NIDS];
  idx_t tail_d [NIDS];

  logic                 full;
  logic                 accept;
  logic                 id_hit;
  logic                 ret_hit;
  logic                 any_exp;
  logic                 unwanted;
  logic                 aw_live;
  logic                 link_en;
  idx_t                 free_idx;
  idx_t                 exp_idx;
  idx_t                 ret_idx;
  idx_t                 link_idx;
  logic [SUM_W-1:0]     sum_len;
  logic [SUM_W-1:0]     beats;
  logic [PROD_W-1:0]    prod;
  logic [`WG_CNT_W-1:0] load_cnt;
  logic [SLOTS-1:0]     taken;

  // Table scan: free slot, response match, expiry and summed lengths
  always_comb begin
    full     = 1'b1;
    free_idx = '0;
    id_hit   = 1'b0;
    any_exp  = 1'b0;
    exp_idx  = '0;
    sum_len  = '0;
    // Walk downwards so the lowest index wins
    for (int i = SLOTS - 1; i >= 0; i--) begin
      if (state_q[i] == SLOT_FREE) begin
        full     = 1'b0;
        free_idx = idx_t'(i);
      end
      if (state_q[i] == SLOT_PENDING) begin
        sum_len = sum_len + SUM_W'(len_q[i]);
        if (id_q[i] == b_id_i) begin
          id_hit = 1'b1;
        end
        if (cnt_q[i] == '0) begin
          any_exp = 1'b1;
          exp_idx = idx_t'(i);
        end
      end
    end
  end

  assign ret_hit  = b_fire_i && id_hit;
  assign ret_idx  = head_q[b_id_i];
  assign unwanted = b_fire_i && !id_hit;

  // Per-slot view for this cycle, expiry takes precedence over retirement
  always_comb begin
    aw_live = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      if (state_q[i] == SLOT_FREE) begin
        slot_view[i] = SLOT_FREE;
      end else if (cnt_q[i] == '0) begin
        slot_view[i] = SLOT_EXPIRED;
      end else if (ret_hit && (ret_idx == idx_t'(i))) begin
        slot_view[i] = SLOT_DONE;
      end else begin
        slot_view[i] = SLOT_PENDING;
      end
      // Same ID still queued once this cycle's retirement is done
      if ((slot_view[i] == SLOT_PENDING) && (id_q[i] == aw_id_i)) begin
        aw_live = 1'b1;
      end
    end
  end

  // Budget for a new write, saturating
  assign beats    = SUM_W'(1) + sum_len + SUM_W'(aw_len_i);
  assign prod     = PROD_W'(budget_i) * PROD_W'(beats);
  assign load_cnt = (|prod[PROD_W-1:`WG_CNT_W]) ? '1 : prod[`WG_CNT_W-1:0];

  assign accept   = aw_valid_i && aw_ready_i && !full && !hold_i && !err_valid_o;
  assign link_idx = tail_q[aw_id_i];

  always_comb begin
    head_d  = head_q;
    tail_d  = tail_q;
    link_en = 1'b0;
    for (int i = 0; i < SLOTS; i++) begin
      case (slot_view[i])
        SLOT_FREE:    state_d[i] = (accept && (free_idx == idx_t'(i))) ? SLOT_PENDING
                                                                      : SLOT_FREE;
        SLOT_PENDING: state_d[i] = SLOT_PENDING;
        default:      state_d[i] = SLOT_FREE;
      endcase
      if (err_valid_o) begin
        state_d[i] = SLOT_FREE;
      end
    end
    // Advance the list of the answered ID
    if (ret_hit && (head_q[b_id_i] != tail_q[b_id_i])) begin
      head_d[b_id_i] = next_q[ret_idx];
    end
    // Append the new write, or start a fresh list
    if (accept) begin
      tail_d[aw_id_i] = free_idx;
      if (aw_live) begin
        link_en = 1'b1;
      end else begin
        head_d[aw_id_i] = free_idx;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < SLOTS; i++) begin
        state_q[i] <= SLOT_FREE;
      end
      for (int n = 0; n < NIDS; n++) begin
        head_q[n] <= '0;
        tail_q[n] <= '0;
      end
    end else begin
      state_q <= state_d;
      head_q  <= head_d;
      tail_q  <= tail_d;
    end
  end

  // Slot payload and budget counters
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < SLOTS; i++) begin
      if (accept && (free_idx == idx_t'(i))) begin
        id_q[i]   <= aw_id_i;
        addr_q[i] <= aw_addr_i;
        len_q[i]  <= aw_len_i;
        cnt_q[i]  <= load_cnt;
      end else if (tick_i && (state_q[i] == SLOT_PENDING) && (cnt_q[i] != '0)) begin
        cnt_q[i] <= cnt_q[i] - 1'b1;
      end
    end
    if (link_en) begin
      next_q[link_idx] <= free_idx;
    end
  end

  // Errors and retirement
  assign err_valid_o      = any_exp || unwanted;
  assign err_timeout_o    = any_exp;
  assign err_unwanted_o   = unwanted;
  assign err_id_o         = any_exp ? id_q[exp_idx] : b_id_i;
  assign err_addr_o       = any_exp ? addr_q[exp_idx] : '0;
  assign retire_valid_o   = ret_hit && !err_valid_o;
  assign retire_latency_o = cnt_q[ret_idx];

  for (genvar i = 0; i < SLOTS; i++) begin : gen_slot_chk
    assign taken[i] = (state_q[i] == SLOT_FREE) && (state_d[i] == SLOT_PENDING);

    // Retired slot was in flight and is free on the next cycle
    a_retire_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (retire_valid_o && (ret_idx == idx_t'(i))) |->
        (state_q[i] == SLOT_PENDING) ##1 (state_q[i] == SLOT_FREE));
  end

  a_one_alloc: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(taken));

endmodule

`default_nettype wire

/* wg_resp_sampler.sv */
// Write guard response sampler
// Generates the budget tick and registers each B handshake into a single pulse

`timescale 1ns/1ps
`default_nettype none

`include "wg_settings.svh"

module wg_resp_sampler (
  input  wire                 clk_i,
  input  wire                 rst_ni,
  input  wire                 b_valid_i,
  input  wire                 b_ready_i,
  input  wire [`WG_ID_W-1:0]  b_id_i,
  output logic                tick_o,
  output logic                b_fire_o,
  output logic [`WG_ID_W-1:0] b_id_o
);

  localparam int PW = (`WG_PRESCALE > 1) ? $clog2(`WG_PRESCALE) : 1;

  logic [PW-1:0] presc_q;

  // Free-running prescaler, tick on the last count
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      presc_q <= '0;
    end else if (presc_q == PW'(`WG_PRESCALE - 1)) begin
      presc_q <= '0;
    end else begin
      presc_q <= presc_q + 1'b1;
    end
  end

  assign tick_o = (presc_q == PW'(`WG_PRESCALE - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      b_fire_o <= 1'b0;
    end else begin
      b_fire_o <= b_valid_i && b_ready_i;
    end
  end

  // ID only matters together with b_fire_o
  always_ff @(posedge clk_i) begin
    if (b_valid_i && b_ready_i) begin
      b_id_o <= b_id_i;
    end
  end

  a_tick_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((`WG_PRESCALE > 1) && tick_o) |=> !tick_o);

endmodule

`default_nettype wire

/* wg_pkg.sv */
// Write guard shared types
// Slot states of the tracker and opcodes of the register port

`default_nettype none

package wg_pkg;

  // Per-slot state as seen by the tracker
  typedef enum logic [1:0] {
    SLOT_FREE    = 2'd0,
    // Counting down, waiting for its response
    SLOT_PENDING = 2'd1,
    // Response matched, slot is released this cycle
    SLOT_DONE    = 2'd2,
    SLOT_EXPIRED = 2'd3
  } slot_state_e;

  // Register port address map
  typedef enum logic [2:0] {
    REG_BUDGET   = 3'd0,
    REG_STATUS   = 3'd1,
    REG_IRQ_ADDR = 3'd2,
    REG_LATENCY  = 3'd3,
    REG_RESET    = 3'd4
  } reg_op_e;

endpackage

`default_nettype wire

/* wg_settings.svh */
// Write guard build settings
// Slot count, field widths and the budget prescaler

`ifndef WG_SETTINGS_SVH
`define WG_SETTINGS_SVH

// Outstanding writes tracked at once
`define WG_SLOTS 4

// Watched bus field widths
`define WG_ID_W 3
`define WG_ADDR_W 32
`define WG_LEN_W 8

// Budget counter width and clock cycles per budget tick
`define WG_CNT_W 16
`define WG_PRESCALE 4

`endif
